// File: build.f
+incdir+include
verilog/elink_tx_pkg.sv
verilog/txn_sync_fifo.sv
verilog/txn_arbiter.sv
verilog/link_framer.sv
verilog/tx_csr_wb.sv
verilog/elink_tx_top.sv
verification/elink_tx_tb.sv

// File: include/elink_tx_tb_tasks.svh
// Testbench LFSR functions, Wishbone bus tasks and typed compare tasks
`ifndef ELINK_TX_TB_TASKS_SVH
`define ELINK_TX_TB_TASKS_SVH

// One Fibonacci step, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// Next 32-bit word with one step per bit
function automatic logic [31:0] lfsr_word(input logic [31:0] s);
  logic [31:0] r;
  r = s;
  for (int i = 0; i < 32; i++)
    r = lfsr_step(r);
  return r;
endfunction

//############################
//# Wishbone master
//############################

task automatic wb_access(input logic we, input logic [3:0] adr,
                         input logic [31:0] dat_w, output logic [31:0] dat_r);
  @(posedge txo_lclk);
  #5;
  wb_cyc   = 1'b1;
  wb_stb   = 1'b1;
  wb_we    = we;
  wb_adr   = adr;
  wb_dat_w = dat_w;
  @(posedge txo_lclk);
  #5;
  while (!wb_ack) begin  // Wait for the slave
    @(posedge txo_lclk);
    #5;
  end
  dat_r  = wb_dat_r;
  wb_cyc = 1'b0;         // Stb falls after ack
  wb_stb = 1'b0;
  wb_we  = 1'b0;
endtask

//############################
//# Compare
//############################

task automatic report_fail(input string name, input logic [71:0] got,
                           input logic [71:0] exp);
  $display("FAIL %s got %h expected %h", name, got, exp);
  $display("Regression failed");
  $fatal(1);
endtask

task automatic compare_head(input string name, input elink_tx_pkg::tx_head_t got,
                            input elink_tx_pkg::tx_head_t exp);
  if (got !== exp)
    report_fail(name, got, exp);
endtask

task automatic compare_body(input string name, input elink_tx_pkg::tx_body_t got,
                            input elink_tx_pkg::tx_body_t exp);
  if (got !== exp)
    report_fail(name, got, exp);
endtask

task automatic compare_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
  if (got !== exp)
    report_fail(name, {40'd0, got}, {40'd0, exp});
endtask

`endif

// File: verification/elink_tx_tb.sv
// Link transmitter testbench with clocks, reset, watchdog, stimulus table and frame monitor
`timescale 1ns/1ps
module elink_tx_tb;
  import elink_tx_pkg::*;

  localparam int          fifo_aw      = 2;
  localparam int unsigned burst_stride = 4;
  localparam int          fifo_depth   = 2 ** fifo_aw;

  // One stimulus row
  typedef struct packed {
    logic [7:0]  test;
    logic        write;
    logic [1:0]  datamode;
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;
    logic        wr_hold;   // Drives txi_wr_wait
    logic        rd_hold;   // Drives txi_rd_wait
    logic        burst_en;
    logic        link_en;
    logic        hdr;       // Header beat expected
  } stim_row_t;

  typedef struct packed {
    logic       hdr;
    emesh_txn_t txn;
  } exp_txn_t;

  logic        reset;
  logic        txo_lclk;
  logic        emesh_clk;
  logic        emesh_access;
  emesh_txn_t  emesh_txn;
  logic        wr_wait, rd_wait;
  logic        txi_wr_wait, txi_rd_wait;
  logic        wb_cyc, wb_stb, wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat_w, wb_dat_r;
  logic        wb_ack;
  tx_frame_u   tx_in;

  stim_row_t   table_q [$];
  exp_txn_t    exp_wr [$];      // Per-class expected order
  exp_txn_t    exp_rd [$];
  logic [31:0] lfsr_state;
  logic        wr_hold, rd_hold; // Class must stay silent
  logic        body_due;         // Header seen, body next
  exp_txn_t    cur_exp;
  tx_ctrl_t    cur_ctrl;         // Last value written to ctrl

  `include "elink_tx_tb_tasks.svh"

  elink_tx_top #(.fifo_aw(fifo_aw), .burst_stride(burst_stride)) DUT (
    .reset(reset), .txo_lclk(txo_lclk), .emesh_clk(emesh_clk),
    .emesh_access(emesh_access), .emesh_txn(emesh_txn),
    .wr_wait(wr_wait), .rd_wait(rd_wait),
    .txi_wr_wait(txi_wr_wait), .txi_rd_wait(txi_rd_wait),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .tx_in(tx_in)
  );

  always #50 txo_lclk = ~txo_lclk;   // 100 ns link clock
  always #65 emesh_clk = ~emesh_clk; // 130 ns mesh clock

  //############################
  //# Stimulus table
  //############################

  task automatic add_row(input logic [7:0] test, input logic wr, input logic [1:0] dm,
                         input logic [3:0] cm, input logic [31:0] addr, input logic ww,
                         input logic rw, input logic be, input logic le, input logic hdr);
    table_q.push_back('{test, wr, dm, cm, addr, ww, rw, be, le, hdr});
  endtask

  task automatic fill_table();
    // test, write, datamode, ctrlmode, dstaddr, wr_hold, rd_hold, burst, link, hdr
    add_row(8'd1, 1, 2'd2, 4'h0, 32'h0000_1000, 0, 0, 0, 1, 1);
    add_row(8'd2, 0, 2'd2, 4'h0, 32'h0000_2000, 0, 0, 0, 1, 1);  // Mixed classes
    add_row(8'd2, 1, 2'd1, 4'h3, 32'h0000_2004, 0, 0, 0, 1, 1);
    add_row(8'd2, 0, 2'd0, 4'h5, 32'h0000_2010, 0, 0, 0, 1, 1);
    add_row(8'd2, 1, 2'd1, 4'h3, 32'h0000_2008, 0, 0, 0, 1, 1);  // Burst off, head kept
    add_row(8'd2, 0, 2'd2, 4'h0, 32'h0000_2014, 0, 0, 0, 1, 1);
    add_row(8'd3, 1, 2'd2, 4'h1, 32'h0000_3000, 0, 0, 1, 1, 1);  // Burst start
    add_row(8'd3, 1, 2'd2, 4'h1, 32'h0000_3004, 0, 0, 1, 1, 0);
    add_row(8'd3, 1, 2'd2, 4'h1, 32'h0000_3008, 0, 0, 1, 1, 0);
    add_row(8'd3, 1, 2'd3, 4'h1, 32'h0000_300c, 0, 0, 1, 1, 1);  // Mode change
    add_row(8'd3, 1, 2'd3, 4'h1, 32'h0000_3010, 0, 0, 1, 1, 0);
    add_row(8'd3, 0, 2'd3, 4'h1, 32'h0000_3014, 0, 0, 1, 1, 1);  // Read breaks
    add_row(8'd3, 1, 2'd3, 4'h1, 32'h0000_3014, 0, 0, 1, 1, 1);
    add_row(8'd3, 1, 2'd3, 4'h1, 32'h0000_3018, 0, 0, 1, 1, 0);
    add_row(8'd3, 1, 2'd3, 4'h1, 32'h0000_3020, 0, 0, 1, 1, 1);  // Wrong stride
    add_row(8'd4, 1, 2'd2, 4'h0, 32'h0000_4000, 1, 0, 0, 1, 1);  // Far write wait
    add_row(8'd4, 1, 2'd2, 4'h0, 32'h0000_4004, 1, 0, 0, 1, 1);
    add_row(8'd4, 1, 2'd2, 4'h0, 32'h0000_4008, 1, 0, 0, 1, 1);
    add_row(8'd4, 1, 2'd2, 4'h0, 32'h0000_400c, 1, 0, 0, 1, 1);  // FIFO full here
    add_row(8'd4, 0, 2'd0, 4'h0, 32'h0000_4100, 1, 0, 0, 1, 1);  // Read still passes
    add_row(8'd4, 1, 2'd2, 4'h0, 32'h0000_4010, 0, 0, 0, 1, 1);  // Release
    add_row(8'd5, 1, 2'd1, 4'h2, 32'h0000_5000, 0, 0, 0, 0, 1);  // Link off
    add_row(8'd5, 0, 2'd1, 4'h2, 32'h0000_5100, 0, 0, 0, 0, 1);
    add_row(8'd5, 1, 2'd1, 4'h2, 32'h0000_5008, 0, 0, 0, 0, 1);
    add_row(8'd5, 0, 2'd1, 4'h2, 32'h0000_5104, 0, 0, 0, 0, 1);
    add_row(8'd5, 1, 2'd1, 4'h2, 32'h0000_5010, 0, 0, 0, 1, 1);  // Link back on
  endtask

  //############################
  //# Drivers
  //############################

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Control register and far wait flags for one row
  task automatic setup_row(input stim_row_t r);
    tx_ctrl_t    want;
    logic [31:0] rd_val;
    want.link_en  = r.link_en;
    want.burst_en = r.burst_en;
    wr_hold = r.wr_hold | ~r.link_en;
    rd_hold = r.rd_hold | ~r.link_en;
    if (want != cur_ctrl) begin
      wb_access(1'b1, csr_ctrl, {30'd0, want}, rd_val);
      wb_access(1'b0, csr_ctrl, 32'd0, rd_val);    // Read back
      compare_word("wb_dat_r", rd_val, {30'd0, want});
      cur_ctrl = want;
    end
    @(posedge txo_lclk);
    #5;
    txi_wr_wait = r.wr_hold;
    txi_rd_wait = r.rd_hold;
    repeat (3) @(posedge txo_lclk);  // Through the two-flop sync
  endtask

  // One mesh transaction, held while its wait flag is high
  task automatic send_txn(input stim_row_t r);
    emesh_txn_t t;
    exp_txn_t   e;
    t.write    = r.write;
    t.datamode = r.datamode;
    t.ctrlmode = r.ctrlmode;
    t.dstaddr  = r.dstaddr;
    lfsr_state = lfsr_word(lfsr_state);
    t.data     = lfsr_state;
    lfsr_state = lfsr_word(lfsr_state);
    t.srcaddr  = lfsr_state;
    @(posedge emesh_clk);
    #5;
    emesh_access = 1'b1;
    emesh_txn    = t;
    while (t.write ? wr_wait : rd_wait) begin
      @(posedge emesh_clk);
      #5;
    end
    @(posedge emesh_clk);            // Accepted on this edge
    e.hdr = r.hdr;
    e.txn = t;
    if (t.write)
      exp_wr.push_back(e);
    else
      exp_rd.push_back(e);
    #5;
    emesh_access = 1'b0;
  endtask

  // Until every class that may send has sent all it holds
  task automatic wait_drain(input logic wr_blk, input logic rd_blk);
    while (!((wr_blk || exp_wr.size() == 0) && (rd_blk || exp_rd.size() == 0)))
      @(negedge txo_lclk);
    repeat (2) @(negedge txo_lclk);
  endtask

  //############################
  //# Frame monitor
  //############################

  function automatic tx_head_t make_head(input emesh_txn_t t);
    tx_head_t h;
    h          = '0;         // Pad stays zero
    h.ftype    = frame_head;
    h.write    = t.write;
    h.datamode = t.datamode;
    h.ctrlmode = t.ctrlmode;
    h.dstaddr  = t.dstaddr;
    return h;
  endfunction

  function automatic tx_body_t make_body(input emesh_txn_t t);
    tx_body_t b;
    b         = '0;
    b.ftype   = frame_body;
    b.data    = t.data;
    b.srcaddr = t.srcaddr;
    return b;
  endfunction

  task automatic retire(input logic is_wr);
    exp_txn_t e;
    if (is_wr)
      e = exp_wr.pop_front();
    else
      e = exp_rd.pop_front();
  endtask

  task automatic check_beat();
    tx_frame_u frm;
    exp_txn_t  e;
    frm = tx_in;
    if (body_due) begin              // Second beat of a header txn
      if (frm.body.ftype != frame_body)
        abort_run("body beat missing after a header");
      compare_body("tx_in.body", frm.body, make_body(cur_exp.txn));
      retire(cur_exp.txn.write);
      body_due = 1'b0;
    end else begin
      case (frm.head.ftype)
        frame_idle: compare_head("tx_in.idle", frm.head, '0);
        frame_head: begin
          if (frm.head.write ? wr_hold : rd_hold)
            abort_run("frame sent while its class is held");
          if (frm.head.write ? exp_wr.size() == 0 : exp_rd.size() == 0)
            abort_run("header sent with no transaction pending");
          e = frm.head.write ? exp_wr[0] : exp_rd[0];
          if (!e.hdr)
            abort_run("header sent for a burst continuation");
          compare_head("tx_in.head", frm.head, make_head(e.txn));
          cur_exp  = e;
          body_due = 1'b1;
        end
        frame_body: begin            // Burst continuation, writes only
          if (wr_hold)
            abort_run("write frame sent while writes are held");
          if (exp_wr.size() == 0)
            abort_run("body sent with no write pending");
          e = exp_wr[0];
          if (e.hdr)
            abort_run("body sent without its header");
          compare_body("tx_in.body", frm.body, make_body(e.txn));
          retire(1'b1);
        end
        default: abort_run("unknown frame type on tx_in");
      endcase
    end
  endtask

  initial begin : monitor
    wait (reset === 1'b0);
    forever begin
      @(negedge txo_lclk);           // Mid-cycle, tx_in stable
      check_beat();
    end
  end

  //############################
  //# Watchdog
  //############################

  initial begin : watchdog
    wait (table_q.size() > 0);
    repeat (table_q.size() * 40) @(posedge txo_lclk);
    $display("timed out waiting for frames");
    $display("Regression failed");
    $fatal(1);
  end

  //############################
  //# Main sequence
  //############################

  initial begin : main
    stim_row_t   r;
    logic [31:0] rd_val;
    int          n_wr;
    int          n_rd;
    txo_lclk     = 1'b0;
    emesh_clk    = 1'b0;
    reset        = 1'b1;
    emesh_access = 1'b0;
    emesh_txn    = '0;
    txi_wr_wait  = 1'b0;
    txi_rd_wait  = 1'b0;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = '0;
    wb_dat_w     = '0;
    lfsr_state   = 32'h5e92aad4;
    wr_hold      = 1'b0;
    rd_hold      = 1'b0;
    body_due     = 1'b0;
    cur_ctrl     = '{link_en: 1'b1, burst_en: 1'b0};  // Reset value
    n_wr         = 0;
    n_rd         = 0;
    fill_table();
    repeat (4) @(posedge txo_lclk);
    #5;
    reset = 1'b0;
    compare_word("wr_wait", {31'd0, wr_wait}, 32'd0);
    compare_word("rd_wait", {31'd0, rd_wait}, 32'd0);
    compare_word("wb_ack", {31'd0, wb_ack}, 32'd0);

    for (int i = 0; i < table_q.size(); i++) begin
      r = table_q[i];
      setup_row(r);
      send_txn(r);
      wait_drain(wr_hold, rd_hold);
      if (r.write)
        n_wr++;
      else
        n_rd++;
      // Held FIFO content decides the mesh wait
      if (wr_hold)
        compare_word("wr_wait", {31'd0, wr_wait}, {31'd0, exp_wr.size() == fifo_depth});
      if (rd_hold)
        compare_word("rd_wait", {31'd0, rd_wait}, {31'd0, exp_rd.size() == fifo_depth});
    end

    wb_access(1'b0, csr_wr_count, 32'd0, rd_val);
    compare_word("wr_count", rd_val, 32'(n_wr));
    wb_access(1'b0, csr_rd_count, 32'd0, rd_val);
    compare_word("rd_count", rd_val, 32'(n_rd));
    wb_access(1'b0, 4'd9, 32'd0, rd_val);  // Unmapped
    compare_word("wb_dat_r", rd_val, 32'd0);

    if (exp_wr.size() != 0 || exp_rd.size() != 0 || body_due) begin
      $display("frames still outstanding at the end of the run");
      $display("Regression failed");
      $fatal(1);
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

endmodule

// File: verilog/elink_tx_top.sv
// Link transmitter top with mesh split, FIFOs, arbiter, framer and registers
`timescale 1ns/1ps
module elink_tx_top #(
  parameter int          fifo_aw      = 2,  // FIFO address width
  parameter int unsigned burst_stride = 4
) (
  input  logic                     reset,
  input  logic                     txo_lclk,
  input  logic                     emesh_clk,
  input  logic                     emesh_access,
  input  elink_tx_pkg::emesh_txn_t emesh_txn,
  output logic                     wr_wait,      // Write FIFO full
  output logic                     rd_wait,      // Read FIFO full
  input  logic                     txi_wr_wait,  // From far receiver
  input  logic                     txi_rd_wait,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [3:0]               wb_adr,
  input  logic [31:0]              wb_dat_w,
  output logic [31:0]              wb_dat_r,
  output logic                     wb_ack,
  output elink_tx_pkg::tx_frame_u  tx_in
);
  import elink_tx_pkg::*;

  logic       wr_push, rd_push;
  logic       wr_pop, rd_pop;
  logic       wr_empty, rd_empty;
  emesh_txn_t wr_head, rd_head;
  logic       sel_valid;
  emesh_txn_t sel_txn;
  logic       frm_busy;
  logic       sent_wr, sent_rd;
  tx_ctrl_t   ctrl;

  // Split mesh traffic by class
  assign wr_push = emesh_access & emesh_txn.write & ~wr_wait;
  assign rd_push = emesh_access & ~emesh_txn.write & ~rd_wait;

  txn_sync_fifo #(.fifo_aw(fifo_aw)) wr_queue (
    .reset(reset), .wr_clk(emesh_clk), .rd_clk(txo_lclk),
    .push(wr_push), .push_txn(emesh_txn), .full(wr_wait),
    .pop(wr_pop), .head_txn(wr_head), .empty(wr_empty)
  );

  txn_sync_fifo #(.fifo_aw(fifo_aw)) rd_queue (
    .reset(reset), .wr_clk(emesh_clk), .rd_clk(txo_lclk),
    .push(rd_push), .push_txn(emesh_txn), .full(rd_wait),
    .pop(rd_pop), .head_txn(rd_head), .empty(rd_empty)
  );

  txn_arbiter arbiter (
    .txo_lclk(txo_lclk), .reset(reset),
    .txi_wr_wait(txi_wr_wait), .txi_rd_wait(txi_rd_wait),
    .wr_empty(wr_empty), .rd_empty(rd_empty),
    .wr_head(wr_head), .rd_head(rd_head),
    .frm_busy(frm_busy), .link_en(ctrl.link_en),
    .wr_pop(wr_pop), .rd_pop(rd_pop),
    .sel_valid(sel_valid), .sel_txn(sel_txn)
  );

  link_framer #(.burst_stride(burst_stride)) framer (
    .txo_lclk(txo_lclk), .reset(reset),
    .sel_valid(sel_valid), .sel_txn(sel_txn), .burst_en(ctrl.burst_en),
    .frm_busy(frm_busy), .tx_frame(tx_in),
    .sent_wr(sent_wr), .sent_rd(sent_rd)
  );

  tx_csr_wb csr (
    .txo_lclk(txo_lclk), .reset(reset),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w),
    .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .sent_wr(sent_wr), .sent_rd(sent_rd), .ctrl(ctrl)
  );

endmodule

// File: verilog/tx_csr_wb.sv
// Wishbone classic register block with link control and sent counters
`timescale 1ns/1ps
module tx_csr_wb (
  input  logic                   txo_lclk,
  input  logic                   reset,
  input  logic                   wb_cyc,
  input  logic                   wb_stb,
  input  logic                   wb_we,
  input  logic [3:0]             wb_adr,    // Word offset
  input  logic [31:0]            wb_dat_w,
  output logic [31:0]            wb_dat_r,
  output logic                   wb_ack,
  input  logic                   sent_wr,   // One pulse per write sent
  input  logic                   sent_rd,
  output elink_tx_pkg::tx_ctrl_t ctrl
);
  import elink_tx_pkg::*;

  logic        acc;        // First cycle of a bus access
  logic        wr_acc;
  logic [31:0] wr_count;
  logic [31:0] rd_count;
  logic [31:0] rd_mux;

  assign acc    = wb_cyc & wb_stb & ~wb_ack;
  assign wr_acc = acc & wb_we;

  //############################
  //# Ack and registers
  //############################

  always_ff @(posedge txo_lclk or posedge reset) begin
    if (reset) begin
      wb_ack   <= 1'b0;
      ctrl     <= '{link_en: 1'b1, burst_en: 1'b0};
      wr_count <= '0;
      rd_count <= '0;
    end else begin
      wb_ack <= acc;  // Single-cycle ack
      if (wr_acc && wb_adr == csr_ctrl)
        ctrl <= tx_ctrl_t'(wb_dat_w[1:0]);
      // Write clears, clear beats a same-cycle count
      if (wr_acc && wb_adr == csr_wr_count)
        wr_count <= '0;
      else if (sent_wr)
        wr_count <= wr_count + 32'd1;
      if (wr_acc && wb_adr == csr_rd_count)
        rd_count <= '0;
      else if (sent_rd)
        rd_count <= rd_count + 32'd1;
    end
  end

  //############################
  //# Read data
  //############################

  always_comb begin
    case (wb_adr)
      csr_ctrl:     rd_mux = {30'd0, ctrl};
      csr_wr_count: rd_mux = wr_count;
      csr_rd_count: rd_mux = rd_count;
      default:      rd_mux = '0;  // Unmapped
    endcase
  end

  // Returned together with ack
  always_ff @(posedge txo_lclk) begin
    if (acc)
      wb_dat_r <= rd_mux;
  end

endmodule

// File: verilog/link_framer.sv
// Framer turning transactions into header and body beats with burst suppression
`timescale 1ns/1ps
module link_framer #(
  parameter int unsigned burst_stride = 4  // Address step of a burst
) (
  input  logic                     txo_lclk,
  input  logic                     reset,
  input  logic                     sel_valid,
  input  elink_tx_pkg::emesh_txn_t sel_txn,
  input  logic                     burst_en,
  output logic                     frm_busy,
  output elink_tx_pkg::tx_frame_u  tx_frame,  // To serdes
  output logic                     sent_wr,
  output logic                     sent_rd
);
  import elink_tx_pkg::*;

  emesh_txn_t  held_txn;       // Captured, waiting for its body beat
  logic        pend_body;
  logic [31:0] last_addr;      // Last write sent
  logic [1:0]  last_datamode;
  logic [3:0]  last_ctrlmode;
  logic        last_vld;
  logic        burst_en_q;
  logic        burst_chg;
  logic        is_burst;
  emesh_txn_t  body_src;
  tx_frame_u   head_beat, body_beat;

  assign frm_busy  = pend_body;  // Header beat on the wire
  assign burst_chg = burst_en ^ burst_en_q;

  // Continuation of the previous write
  assign is_burst = burst_en & ~burst_chg & last_vld & sel_txn.write &
                    (sel_txn.datamode == last_datamode) &
                    (sel_txn.ctrlmode == last_ctrlmode) &
                    (sel_txn.dstaddr == last_addr + burst_stride);

  assign body_src = pend_body ? held_txn : sel_txn;

  //############################
  //# Beat views
  //############################

  always_comb begin
    head_beat               = '0;
    head_beat.head.ftype    = frame_head;
    head_beat.head.write    = sel_txn.write;
    head_beat.head.datamode = sel_txn.datamode;
    head_beat.head.ctrlmode = sel_txn.ctrlmode;
    head_beat.head.dstaddr  = sel_txn.dstaddr;
    body_beat               = '0;
    body_beat.body.ftype    = frame_body;
    body_beat.body.data     = body_src.data;
    body_beat.body.srcaddr  = body_src.srcaddr;
  end

  //############################
  //# Beat sequencing
  //############################

  always_ff @(posedge txo_lclk or posedge reset) begin
    if (reset) begin
      tx_frame  <= '0;
      pend_body <= 1'b0;
      sent_wr   <= 1'b0;
      sent_rd   <= 1'b0;
    end else begin
      sent_wr <= 1'b0;
      sent_rd <= 1'b0;
      if (pend_body) begin          // Second beat of a header txn
        tx_frame  <= body_beat;
        pend_body <= 1'b0;
        sent_wr   <= held_txn.write;
        sent_rd   <= ~held_txn.write;
      end else if (sel_valid && is_burst) begin
        tx_frame <= body_beat;      // Header suppressed
        sent_wr  <= 1'b1;
      end else if (sel_valid) begin
        tx_frame  <= head_beat;
        pend_body <= 1'b1;
      end else begin
        tx_frame <= '0;             // frame_idle
      end
    end
  end

  always_ff @(posedge txo_lclk) begin
    if (sel_valid)
      held_txn <= sel_txn;
  end

  // Burst tracking
  always_ff @(posedge txo_lclk or posedge reset) begin
    if (reset) begin
      last_vld      <= 1'b0;
      last_addr     <= '0;
      last_datamode <= '0;
      last_ctrlmode <= '0;
      burst_en_q    <= 1'b0;
    end else begin
      burst_en_q <= burst_en;
      if (sel_valid && sel_txn.write) begin
        last_vld      <= 1'b1;
        last_addr     <= sel_txn.dstaddr;
        last_datamode <= sel_txn.datamode;
        last_ctrlmode <= sel_txn.ctrlmode;
      end else if (sel_valid || burst_chg) begin
        last_vld <= 1'b0;           // Read or mode switch breaks it
      end
    end
  end

endmodule

// File: verilog/txn_arbiter.sv
// Wait flag synchronizer, FIFO read gating and round-robin write/read select
`timescale 1ns/1ps
module txn_arbiter (
  input  logic                     txo_lclk,
  input  logic                     reset,
  input  logic                     txi_wr_wait,  // Async from far receiver
  input  logic                     txi_rd_wait,
  input  logic                     wr_empty,
  input  logic                     rd_empty,
  input  elink_tx_pkg::emesh_txn_t wr_head,
  input  elink_tx_pkg::emesh_txn_t rd_head,
  input  logic                     frm_busy,     // Framer in header beat
  input  logic                     link_en,
  output logic                     wr_pop,
  output logic                     rd_pop,
  output logic                     sel_valid,
  output elink_tx_pkg::emesh_txn_t sel_txn
);

  logic [1:0] wait_s1, wait_s2;  // {rd, wr}
  logic       wr_ok, rd_ok;
  logic       wr_turn;           // Alternation register

  //############################
  //# Wait flag sync
  //############################

  always_ff @(posedge txo_lclk or posedge reset) begin
    if (reset) begin
      wait_s1 <= '0;
      wait_s2 <= '0;
    end else begin
      wait_s1 <= {txi_rd_wait, txi_wr_wait};
      wait_s2 <= wait_s1;  // Effective two cycles after change
    end
  end

  //############################
  //# Eligibility and grant
  //############################

  // Queue may pop only when framer idle and link up
  assign wr_ok = ~wr_empty & ~wait_s2[0] & ~frm_busy & link_en;
  assign rd_ok = ~rd_empty & ~wait_s2[1] & ~frm_busy & link_en;

  always_ff @(posedge txo_lclk or posedge reset) begin
    if (reset)
      wr_turn <= 1'b0;
    else if (sel_valid)
      wr_turn <= rd_pop;  // Other class first after each grant
  end

  // Lone eligible queue wins over the turn
  assign wr_pop = wr_ok & (wr_turn | ~rd_ok);
  assign rd_pop = rd_ok & (~wr_turn | ~wr_ok);

  assign sel_valid = wr_pop | rd_pop;
  assign sel_txn   = wr_pop ? wr_head : rd_head;  // Steer popped head

endmodule

// File: verilog/txn_sync_fifo.sv
// Dual-clock FIFO of mesh transactions with Gray-coded pointer crossing
`timescale 1ns/1ps
module txn_sync_fifo #(
  parameter int fifo_aw = 2  // Depth is 2**fifo_aw
) (
  input  logic                     reset,
  input  logic                     wr_clk,    // Mesh side
  input  logic                     rd_clk,    // Link side
  input  logic                     push,
  input  elink_tx_pkg::emesh_txn_t push_txn,
  output logic                     full,
  input  logic                     pop,
  output elink_tx_pkg::emesh_txn_t head_txn,
  output logic                     empty
);
  import elink_tx_pkg::*;

  localparam int depth = 2 ** fifo_aw;

  emesh_txn_t mem [depth];  // Storage, no reset

  // Write domain
  logic [fifo_aw:0] wr_bin, wr_bin_nxt, wr_gray;
  logic [fifo_aw:0] rd_gray_w1, rd_gray_w2;  // Read pointer seen by writer
  // Read domain
  logic [fifo_aw:0] rd_bin, rd_bin_nxt, rd_gray;
  logic [fifo_aw:0] wr_gray_r1, wr_gray_r2;  // Write pointer seen by reader

  logic do_push, do_pop;

  assign do_push = push & ~full;  // Guard against overrun
  assign do_pop  = pop & ~empty;

  //############################
  //# Write side
  //############################

  assign wr_bin_nxt = wr_bin + {{fifo_aw{1'b0}}, do_push};

  always_ff @(posedge wr_clk or posedge reset) begin
    if (reset) begin
      wr_bin     <= '0;
      wr_gray    <= '0;
      rd_gray_w1 <= '0;
      rd_gray_w2 <= '0;
    end else begin
      wr_bin     <= wr_bin_nxt;
      wr_gray    <= wr_bin_nxt ^ (wr_bin_nxt >> 1);  // Binary to Gray
      rd_gray_w1 <= rd_gray;     // Two-flop sync
      rd_gray_w2 <= rd_gray_w1;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (do_push)
      mem[wr_bin[fifo_aw-1:0]] <= push_txn;
  end

  // Full when the top two Gray bits differ and the rest match
  assign full = (wr_gray == {~rd_gray_w2[fifo_aw:fifo_aw-1], rd_gray_w2[fifo_aw-2:0]});

  //############################
  //# Read side
  //############################

  assign rd_bin_nxt = rd_bin + {{fifo_aw{1'b0}}, do_pop};

  always_ff @(posedge rd_clk or posedge reset) begin
    if (reset) begin
      rd_bin     <= '0;
      rd_gray    <= '0;
      wr_gray_r1 <= '0;
      wr_gray_r2 <= '0;
    end else begin
      rd_bin     <= rd_bin_nxt;
      rd_gray    <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
      wr_gray_r1 <= wr_gray;     // Crossing latency starts here
      wr_gray_r2 <= wr_gray_r1;
    end
  end

  assign empty    = (rd_gray == wr_gray_r2);
  assign head_txn = mem[rd_bin[fifo_aw-1:0]];  // Head shown combinationally

endmodule

// File: verilog/elink_tx_pkg.sv
// Mesh transaction type, link frame views and union, frame codes, register offsets
package elink_tx_pkg;

  //############################
  //# Mesh side
  //############################

  // One mesh transaction, 103 bits, access strobe travels beside it
  typedef struct packed {
    logic        write;     // 1 = write, 0 = read
    logic [1:0]  datamode;  // Transfer size
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;
    logic [31:0] data;
    logic [31:0] srcaddr;   // Return address for reads
  } emesh_txn_t;

  //############################
  //# Link frames
  //############################

  typedef enum logic [1:0] {
    frame_idle = 2'd0,  // All-zero beat
    frame_head = 2'd1,
    frame_body = 2'd2
  } frame_type_t;

  // Header beat, 72 bits
  typedef struct packed {
    frame_type_t ftype;      // Top two bits in both views
    logic        write;
    logic [1:0]  datamode;
    logic [3:0]  ctrlmode;
    logic [31:0] dstaddr;
    logic [30:0] pad;        // Always zero
  } tx_head_t;

  // Body beat, 72 bits
  typedef struct packed {
    frame_type_t ftype;
    logic [31:0] data;
    logic [31:0] srcaddr;
    logic [5:0]  pad;        // Always zero
  } tx_body_t;

  // Same serdes word, decoded by ftype
  typedef union packed {
    tx_head_t head;
    tx_body_t body;
  } tx_frame_u;

  //############################
  //# Registers
  //############################

  typedef struct packed {
    logic link_en;   // Bit 1
    logic burst_en;  // Bit 0
  } tx_ctrl_t;

  // Word offsets on the Wishbone side
  typedef enum logic [3:0] {
    csr_ctrl     = 4'd0,
    csr_wr_count = 4'd1,
    csr_rd_count = 4'd2
  } csr_addr_e;

endpackage
